// File: Bender.yml
package:
  name: wb_soc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wb_pkg.sv
      - wb_rr_arbiter.sv
      - wb_shared_bus.sv
      - wb_ram_slave.sv
      - wb_gpio_slave.sv
      - wb_soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_soc.sv

// File: tb_wb_soc.sv
// testbench for wb_soc_top with three random masters checked against a RAM and GPIO model
// RAM traffic stays in the lowest 16 words so that reads hit earlier writes
// unwritten RAM lanes are unknown after reset and are not compared
`timescale 1ns/10ps
`include "wb_settings.svh"

module tb_wb_soc;
	import wb_pkg::*;

	localparam int MASTERS    = `WB_MASTERS;
	localparam int NUM_ACC    = 60;  // accesses per master in the random phase
	localparam int BURST_ACC  = 10;  // accesses per master back to back
	localparam int RAM_SPAN   = 16;  // RAM words in use
	localparam int CLK_NS     = 8;
	localparam int SEED       = 55036;
	localparam int TIMEOUT_NS = (NUM_ACC + BURST_ACC) * MASTERS * 12 * CLK_NS;

	logic                  clk;
	logic                  reset;
	wb_req_t               master_req [MASTERS];
	wb_rsp_t               master_rsp [MASTERS];
	logic [`WB_GPIO_W-1:0] gpio_in;
	logic [`WB_GPIO_W-1:0] gpio_out;

	// reference model
	wb_data_t              ram_model [RAM_SPAN];
	wb_sel_t               ram_known [RAM_SPAN]; // lanes written so far
	logic [`WB_GPIO_W-1:0] gpio_shadow;
	int                    cycle_cnt;
	int                    gpio_change_cycle;
	int                    errors;
	int                    pass_cnt [MASTERS][MASTERS]; // [waiting][completing]

	wb_soc_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.master_req_i (master_req),
		.master_rsp_o (master_rsp),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(posedge clk or posedge reset) begin
		if (reset)
			cycle_cnt <= 0;
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		errors++;
	endtask

	function automatic wb_req_t random_request();
		wb_req_t r;
		r = '0;
		case ($urandom_range(2))
			0: r.adr = {`WB_RAM_BASE, 28'h0} | (32'($urandom_range(RAM_SPAN - 1)) << 2);
			1: r.adr = {`WB_GPIO_BASE, 28'h0} | (32'($urandom_range(2)) << 2); // 0, 4, 8
			default: r.adr = {4'h5, 28'h0} | ($urandom & 32'h0fff_fffc);
		endcase
		r.dat = $urandom;
		r.sel = wb_sel_t'($urandom_range(15));
		r.we  = 1'($urandom_range(1));
		r.stb = 1'b1;
		r.cyc = 1'b1;
		return r;
	endfunction

	// response checks and model update for one access
	task automatic check_response(input int m, input wb_req_t req, input int latency,
		input bit idle);
		wb_rsp_t        rsp;
		logic [3:0]     region;
		int             w;
		logic [31:0]    mask;
		string          name;
		rsp    = master_rsp[m];
		region = req.adr[`WB_ADDR_W-1 -: 4];
		name   = $sformatf("master_rsp_o[%0d]", m);
		if (region != `WB_RAM_BASE && region != `WB_GPIO_BASE) begin
			if (rsp.err !== 1'b1 || rsp.ack !== 1'b0)
				value_error({name, ".{ack,err}"}, 32'h1, {30'h0, rsp.ack, rsp.err});
		end else if (rsp.ack !== 1'b1 || rsp.err !== 1'b0) begin
			value_error({name, ".{ack,err}"}, 32'h2, {30'h0, rsp.ack, rsp.err});
		end else if (region == `WB_RAM_BASE) begin
			w = int'(req.adr[9:2]);
			if (req.we) begin
				for (int b = 0; b < `WB_SEL_W; b++) begin
					if (req.sel[b]) begin
						ram_model[w][8*b +: 8] = req.dat[8*b +: 8];
						ram_known[w][b]        = 1'b1;
					end
				end
			end else begin
				for (int b = 0; b < `WB_SEL_W; b++)
					mask[8*b +: 8] = {8{ram_known[w][b]}};
				if ((rsp.dat & mask) !== (ram_model[w] & mask))
					value_error({name, ".dat"}, ram_model[w] & mask, rsp.dat & mask);
			end
		end else begin
			case (req.adr[3:2])
				2'd0: begin
					if (req.we)
						gpio_shadow = req.dat[`WB_GPIO_W-1:0];
					else if (rsp.dat !== 32'(gpio_shadow))
						value_error({name, ".dat"}, 32'(gpio_shadow), rsp.dat);
				end
				2'd1: begin
					// only once the pins have passed the synchronizer
					if (!req.we && cycle_cnt - gpio_change_cycle >= 3 &&
							rsp.dat !== 32'(gpio_in))
						value_error({name, ".dat"}, 32'(gpio_in), rsp.dat);
				end
				default: begin
					if (!req.we && rsp.dat !== 32'h0)
						value_error({name, ".dat"}, 32'h0, rsp.dat);
				end
			endcase
			if (gpio_out !== gpio_shadow)
				value_error("gpio_o", 32'(gpio_shadow), 32'(gpio_out));
		end
		if (idle && latency != 2) begin
			$display("master %0d: response on an idle bus came %0d cycles after cyc, not 2",
				m, latency);
			errors++;
		end
	endtask

	// one master that keeps cyc low for at least one cycle between accesses
	task automatic run_master(input int m, input int count, input int max_gap);
		wb_req_t req;
		int      raise_cycle;
		bit      idle;
		for (int n = 0; n < count; n++) begin
			req = random_request();
			repeat ($urandom_range(max_gap)) @(posedge clk);
			@(posedge clk);
			#1;
			master_req[m] = req;
			raise_cycle   = cycle_cnt;
			@(negedge clk);
			idle = 1'b1;
			for (int j = 0; j < MASTERS; j++) begin
				if (j != m && master_req[j].cyc)
					idle = 1'b0;
			end
			while (!(master_rsp[m].ack || master_rsp[m].err))
				@(negedge clk);
			check_response(m, req, cycle_cnt - raise_cycle, idle);
			@(posedge clk);
			#1;
			master_req[m] = '0;
		end
	endtask

	task automatic drive_gpio();
		forever begin
			repeat (20) @(posedge clk);
			#1;
			gpio_in           = `WB_GPIO_W'($urandom);
			gpio_change_cycle = cycle_cnt;
		end
	endtask

	// protocol and fairness monitor
	always @(negedge clk) begin
		if (!reset) begin
			for (int m = 0; m < MASTERS; m++) begin
				if (!(master_rsp[m].ack || master_rsp[m].err))
					continue;
				if (!master_req[m].cyc) begin
					$display("master %0d got a response while its cyc was low at %0t", m, $time);
					errors++;
				end
				for (int j = 0; j < MASTERS; j++) begin
					if (j != m && master_req[j].cyc) begin
						pass_cnt[j][m]++;
						if (pass_cnt[j][m] > 1) begin
							$display("master %0d completed twice while master %0d waited at %0t",
								m, j, $time);
							errors++;
						end
					end
				end
				for (int k = 0; k < MASTERS; k++)
					pass_cnt[m][k] = 0;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset             = 1'b1;
		gpio_in           = '0;
		gpio_change_cycle = 0;
		gpio_shadow       = '0;
		errors            = 0;
		for (int m = 0; m < MASTERS; m++) begin
			master_req[m] = '0;
			for (int k = 0; k < MASTERS; k++)
				pass_cnt[m][k] = 0;
		end
		for (int w = 0; w < RAM_SPAN; w++) begin
			ram_model[w] = '0;
			ram_known[w] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			drive_gpio();
		join_none
		fork
			run_master(0, NUM_ACC, 3);
			run_master(1, NUM_ACC, 3);
			run_master(2, NUM_ACC, 3);
		join
		// all three saturate the bus so grants must rotate
		fork
			run_master(0, BURST_ACC, 0);
			run_master(1, BURST_ACC, 0);
			run_master(2, BURST_ACC, 0);
		join
		repeat (4) @(posedge clk);
		$display("checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
wb_pkg.sv
wb_rr_arbiter.sv
wb_shared_bus.sv
wb_ram_slave.sv
wb_gpio_slave.sv
wb_soc_top.sv
tb_wb_soc.sv

// File: wb_gpio_slave.sv
// GPIO slave with the output register at offset 0 and the synchronized pins at offset 4
// other offsets read zero and still ack while sel is ignored
// writes to offset 4 are dropped
`timescale 1ns/10ps
`include "wb_settings.svh"

module wb_gpio_slave (
	input  logic                  clk,
	input  logic                  reset,
	input  wb_pkg::wb_req_t       req_i,
	input  logic                  stb_i,
	input  logic [`WB_GPIO_W-1:0] gpio_i,
	output wb_pkg::wb_rsp_t       rsp_o,
	output logic [`WB_GPIO_W-1:0] gpio_o
);
	import wb_pkg::*;

	logic [`WB_GPIO_W-1:0] out_q;
	logic [`WB_GPIO_W-1:0] sync1_q, sync2_q; // pin synchronizer
	logic                  ack_q;
	logic                  access;
	logic                  is_out, is_in;
	wb_data_t              rd_q;

	// word offset inside the region
	assign is_out = (req_i.adr[`WB_ADDR_W-5:2] == '0);
	assign is_in  = (req_i.adr[`WB_ADDR_W-5:2] == 1);
	assign access = stb_i & ~ack_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q   <= 1'b0;
			out_q   <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			ack_q   <= access;
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			if (access && req_i.we && is_out)
				out_q <= req_i.dat[`WB_GPIO_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (is_out)
				rd_q <= wb_data_t'(out_q);   // zero-extended
			else if (is_in)
				rd_q <= wb_data_t'(sync2_q);
			else
				rd_q <= '0;
		end
	end

	always_comb begin
		rsp_o     = '0;
		rsp_o.dat = rd_q;
		rsp_o.ack = ack_q;
	end

	assign gpio_o = out_q;

endmodule

// File: wb_pkg.sv
// types shared by the bus, the arbiter and the slaves
// widths follow the macros of the settings header
`include "wb_settings.svh"

package wb_pkg;

	typedef logic [`WB_ADDR_W-1:0]  wb_addr_t;
	typedef logic [`WB_DATA_W-1:0]  wb_data_t;
	typedef logic [`WB_SEL_W-1:0]   wb_sel_t;
	typedef logic [`WB_MASTERS-1:0] wb_mask_t; // one bit per master

	// master to slave direction, 71 bits
	typedef struct packed {
		wb_addr_t adr;
		wb_data_t dat;
		wb_sel_t  sel;
		logic     we;
		logic     stb;
		logic     cyc;
	} wb_req_t;

	// slave to master direction, 34 bits
	typedef struct packed {
		wb_data_t dat;
		logic     ack;
		logic     err;
	} wb_rsp_t;

	// arbiter ownership
	typedef enum logic {
		ARB_IDLE,
		ARB_OWNED
	} arb_state_e;

endpackage

// File: wb_ram_slave.sv
// word RAM slave, 256 x 32, indexed by adr[9:2], upper address bits ignored
// ack and read data are registered one cycle after stb, never twice in a row
`timescale 1ns/10ps
`include "wb_settings.svh"

module wb_ram_slave (
	input  logic            clk,
	input  logic            reset,
	input  wb_pkg::wb_req_t req_i,
	input  logic            stb_i,
	output wb_pkg::wb_rsp_t rsp_o
);
	import wb_pkg::*;

	localparam int IDX_W = $clog2(`WB_RAM_WORDS);

	wb_data_t         mem [`WB_RAM_WORDS];
	wb_data_t         rd_q;
	logic             ack_q;
	logic [IDX_W-1:0] idx;
	logic             access;

	assign idx    = req_i.adr[2 +: IDX_W];
	assign access = stb_i & ~ack_q; // stb still high during the ack cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// storage and read data
	always_ff @(posedge clk) begin
		if (access) begin
			rd_q <= mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < `WB_SEL_W; b++) begin
					if (req_i.sel[b])
						mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	always_comb begin
		rsp_o     = '0;
		rsp_o.dat = rd_q;
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0; // every word is valid
	end

	// single pulse, right after a strobe
	a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
		rsp_o.ack |-> ($past(stb_i) && !$past(rsp_o.ack)));

endmodule

// File: wb_rr_arbiter.sv
// round-robin arbiter over the cyc vector, grant is registered
// a new grant shows one cycle after its request and is held while cyc stays high
`timescale 1ns/10ps
`include "wb_settings.svh"

module wb_rr_arbiter (
	input  logic             clk,
	input  logic             reset,
	input  wb_pkg::wb_mask_t req_i,
	output wb_pkg::wb_mask_t grant_o
);
	import wb_pkg::*;

	localparam int N     = `WB_MASTERS;
	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	arb_state_e       state_q;
	wb_mask_t         grant_q;
	logic [PTR_W-1:0] ptr_q;    // master after the last winner
	wb_mask_t         winner;
	logic [PTR_W-1:0] next_ptr;
	logic             hold;

	// scan from far to near so the requester closest to ptr is written last
	always_comb begin
		int idx;
		winner   = '0;
		next_ptr = ptr_q;
		for (int k = N - 1; k >= 0; k--) begin
			idx = int'(ptr_q) + k;
			if (idx >= N)
				idx = idx - N;
			if (req_i[idx]) begin
				winner      = '0;
				winner[idx] = 1'b1;
				next_ptr    = (idx == N - 1) ? '0 : PTR_W'(idx + 1);
			end
		end
	end

	assign hold = (state_q == ARB_OWNED) && (|(grant_q & req_i));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= ARB_IDLE;
			grant_q <= '0;
			ptr_q   <= '0;
		end else if (!hold) begin
			grant_q <= winner; // zero when nobody asks
			if (|winner) begin
				state_q <= ARB_OWNED;
				ptr_q   <= next_ptr;
			end else begin
				state_q <= ARB_IDLE;
			end
		end
	end

	assign grant_o = grant_q;

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_o));

	// owner keeps the bus for its whole cycle
	a_grant_held: assert property (@(posedge clk) disable iff (reset)
		(|(grant_o & req_i)) |=> $stable(grant_o));

endmodule

// File: wb_settings.svh
// bus dimensions and address map for the shared wishbone subsystem
// slaves decode on address bits 31:28, one 256MB region each
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// bus population
`define WB_MASTERS    3
`define WB_SLAVES     2

// datapath widths
`define WB_ADDR_W     32
`define WB_DATA_W     32
`define WB_SEL_W      4   // one enable per byte lane

// slave sizes
`define WB_RAM_WORDS  256
`define WB_GPIO_W     16

// region codes in adr[31:28]
// anything else goes to the error responder
`define WB_RAM_BASE   4'h0
`define WB_GPIO_BASE  4'h1

`endif

// File: wb_shared_bus.sv
// shared wishbone classic interconnect, one access in flight at a time
// slave slot 0 is the RAM region, slot 1 the GPIO region
// unmapped accesses get a one-cycle err from the built-in responder
`timescale 1ns/10ps
`include "wb_settings.svh"

module wb_shared_bus (
	input  logic                  clk,
	input  logic                  reset,
	input  wb_pkg::wb_req_t       master_req_i [`WB_MASTERS],
	input  wb_pkg::wb_rsp_t       slave_rsp_i  [`WB_SLAVES],
	output wb_pkg::wb_rsp_t       master_rsp_o [`WB_MASTERS],
	output wb_pkg::wb_req_t       slave_req_o,
	output logic [`WB_SLAVES-1:0] slave_stb_o
);
	import wb_pkg::*;

	localparam int REGION_W = 4; // adr[31:28]

	// region code per slave slot
	localparam logic [REGION_W-1:0] SLAVE_BASE [`WB_SLAVES] = '{
		`WB_RAM_BASE,
		`WB_GPIO_BASE
	};

	wb_mask_t              cyc_vec;
	wb_mask_t              grant;
	wb_req_t               gnt_req;   // request of the granted master
	logic                  gnt_stb;
	logic [`WB_SLAVES-1:0] slave_sel;
	logic                  unmapped;
	logic                  err_q;
	wb_rsp_t               sel_rsp;

	always_comb begin
		for (int m = 0; m < `WB_MASTERS; m++)
			cyc_vec[m] = master_req_i[m].cyc;
	end

	wb_rr_arbiter u_arbiter (
		.clk     (clk),
		.reset   (reset),
		.req_i   (cyc_vec),
		.grant_o (grant)
	);

	// grant is one-hot or zero, so a plain priority pick is enough
	always_comb begin
		gnt_req = '0;
		for (int m = 0; m < `WB_MASTERS; m++) begin
			if (grant[m])
				gnt_req = master_req_i[m];
		end
	end

	assign gnt_stb = gnt_req.stb & gnt_req.cyc;

	// address decode
	always_comb begin
		for (int s = 0; s < `WB_SLAVES; s++)
			slave_sel[s] = (gnt_req.adr[`WB_ADDR_W-1 -: REGION_W] == SLAVE_BASE[s]);
	end

	assign slave_stb_o = slave_sel & {`WB_SLAVES{gnt_stb}};
	assign unmapped    = gnt_stb & ~(|slave_sel);

	// shared fields to all slaves, strobes go out per slot
	always_comb begin
		slave_req_o     = gnt_req;
		slave_req_o.stb = 1'b0;
	end

	// default responder, same one-pulse rule as the slaves
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			err_q <= 1'b0;
		else
			err_q <= unmapped & ~err_q;
	end

	// response of the selected slot plus the default err
	always_comb begin
		sel_rsp = '0;
		for (int s = 0; s < `WB_SLAVES; s++) begin
			if (slave_sel[s])
				sel_rsp = slave_rsp_i[s];
		end
		sel_rsp.err = sel_rsp.err | err_q;
	end

	// only the owner sees data and handshakes
	always_comb begin
		for (int m = 0; m < `WB_MASTERS; m++)
			master_rsp_o[m] = grant[m] ? sel_rsp : '0;
	end

	for (genvar m = 0; m < `WB_MASTERS; m++) begin : g_rsp_chk
		a_ack_err_excl: assert property (@(posedge clk) disable iff (reset)
			!(master_rsp_o[m].ack && master_rsp_o[m].err));

		// a released grant must not leave a late pulse behind
		a_rsp_in_cycle: assert property (@(posedge clk) disable iff (reset)
			(master_rsp_o[m].ack || master_rsp_o[m].err) |-> master_req_i[m].cyc);
	end

endmodule

// File: wb_soc_top.sv
// shared-bus subsystem: three masters, word RAM at region 0, GPIO at region 1
// masters are plain ports and must follow the wishbone classic handshake
`timescale 1ns/10ps
`include "wb_settings.svh"

module wb_soc_top (
	input  logic                  clk,
	input  logic                  reset,
	input  wb_pkg::wb_req_t       master_req_i [`WB_MASTERS],
	output wb_pkg::wb_rsp_t       master_rsp_o [`WB_MASTERS],
	input  logic [`WB_GPIO_W-1:0] gpio_i,
	output logic [`WB_GPIO_W-1:0] gpio_o
);
	import wb_pkg::*;

	wb_req_t               slave_req;
	logic [`WB_SLAVES-1:0] slave_stb;
	wb_rsp_t               slave_rsp [`WB_SLAVES];

	wb_shared_bus u_bus (
		.clk          (clk),
		.reset        (reset),
		.master_req_i (master_req_i),
		.slave_rsp_i  (slave_rsp),
		.master_rsp_o (master_rsp_o),
		.slave_req_o  (slave_req),
		.slave_stb_o  (slave_stb)
	);

	// slot 0
	wb_ram_slave u_ram (
		.clk   (clk),
		.reset (reset),
		.req_i (slave_req),
		.stb_i (slave_stb[0]),
		.rsp_o (slave_rsp[0])
	);

	// slot 1
	wb_gpio_slave u_gpio (
		.clk    (clk),
		.reset  (reset),
		.req_i  (slave_req),
		.stb_i  (slave_stb[1]),
		.gpio_i (gpio_i),
		.rsp_o  (slave_rsp[1]),
		.gpio_o (gpio_o)
	);

endmodule
